//--- build.f
src/exu_pkg.sv
src/exu_decode.sv
src/exu_multi_cyc.sv
src/exu_execute.sv
src/exu_result.sv
src/exu_apb_regs.sv
src/exu_top.sv
tb/exu_assert.sv
tb/tb_exu.sv

//--- Bender.yml
package:
  name: exu

sources:
  - src/exu_pkg.sv
  - src/exu_decode.sv
  - src/exu_multi_cyc.sv
  - src/exu_execute.sv
  - src/exu_result.sv
  - src/exu_apb_regs.sv
  - src/exu_top.sv
  - target: test
    files:
      - tb/exu_assert.sv
      - tb/tb_exu.sv

//--- tb/tb_exu.sv
module tb_exu;
	import exu_pkg::*;

	localparam int DLY        = 2;
	localparam int WAIT_LIMIT = 20;
	localparam int IDLE_LIMIT = 100;

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	word_t       pwdata;
	word_t       prdata;
	logic        pready;
	logic        pslverr;

	word_t rng = 32'hf3de;

	// reference model state and expected results
	word_t      m_hi;
	word_t      m_lo;
	word_t      exp_ret;
	logic       exp_exc;
	logic [4:0] exp_code;
	logic       exp_ce;
	logic       exp_we;
	word_t      exp_addr;
	logic [3:0] exp_sel;
	word_t      exp_wdata;

	oper_t alu_ops [19] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI, OP_ADD, OP_ADDU,
		OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV,
		OP_SRAV, OP_CLZ, OP_CLO};
	oper_t mul_ops [11] = '{OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU, OP_MSUB,
		OP_MSUBU, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO};
	oper_t mem_ops [8] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
	oper_t exc_ops [12] = '{OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU, OP_BREAK,
		OP_SYSCALL, OP_INVALID, OP_MTHI, OP_MTLO, OP_MULT};

	exu_top #(
		.APB_ADDR_W(12),
		.MUL_RADIX_BITS(1)
	) dut0 (
		.clk,
		.rst,
		.psel,
		.penable,
		.pwrite,
		.paddr,
		.pwdata,
		.prdata,
		.pready,
		.pslverr
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic word_t xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t got);
		assert (got === exp)
		else
			stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, got));
	endtask

	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input word_t wdata,
		output word_t rdata, output logic err);
		int n;
		@(posedge clk);
		#DLY;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#DLY;
		penable = 1'b1;
		@(negedge clk);
		n = 0;
		while (!pready && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!pready)
			stop_run("APB transfer never completed, pready stayed low");
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#DLY;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input word_t data);
		word_t unused;
		logic  err;
		apb_xfer(1'b1, addr, data, unused, err);
		check_word($sformatf("write pslverr at %h", addr), 32'd0, {31'b0, err});
	endtask

	task automatic apb_read(input logic [11:0] addr, output word_t data);
		logic err;
		apb_xfer(1'b0, addr, 32'd0, data, err);
		check_word($sformatf("read pslverr at %h", addr), 32'd0, {31'b0, err});
	endtask

	task automatic wait_idle(output word_t st);
		int    n;
		word_t s;
		n = 0;
		apb_read(REG_STATUS, s);
		while ((s[0] || !s[1]) && n < IDLE_LIMIT)
		begin
			apb_read(REG_STATUS, s);
			n++;
		end
		if (s[0] || !s[1])
			stop_run("timed out waiting for the unit to finish its operation");
		st = s;
	endtask

	// MIPS32 encodings, register fields and immediate taken from f
	function automatic word_t make_inst(input oper_t k, input logic imm_form, input word_t f);
		word_t w;
		w = {6'h00, f[25:6], 6'h00};
		if (imm_form)
		begin
			case (k)
			OP_ADD:  w = {6'h08, f[25:0]};
			OP_ADDU: w = {6'h09, f[25:0]};
			OP_SLT:  w = {6'h0A, f[25:0]};
			OP_SLTU: w = {6'h0B, f[25:0]};
			OP_AND:  w = {6'h0C, f[25:0]};
			OP_OR:   w = {6'h0D, f[25:0]};
			OP_XOR:  w = {6'h0E, f[25:0]};
			OP_LUI:  w = {6'h0F, f[25:0]};
			OP_TGE:  w = {6'h01, f[25:21], 5'h08, f[15:0]};
			OP_TGEU: w = {6'h01, f[25:21], 5'h09, f[15:0]};
			OP_TLT:  w = {6'h01, f[25:21], 5'h0A, f[15:0]};
			OP_TLTU: w = {6'h01, f[25:21], 5'h0B, f[15:0]};
			OP_TEQ:  w = {6'h01, f[25:21], 5'h0C, f[15:0]};
			OP_TNE:  w = {6'h01, f[25:21], 5'h0E, f[15:0]};
			default: w = {6'h3F, f[25:0]};
			endcase
		end
		else
		begin
			case (k)
			OP_SLL:     w[5:0] = 6'h00;
			OP_SRL:     w[5:0] = 6'h02;
			OP_SRA:     w[5:0] = 6'h03;
			OP_SLLV:    w[5:0] = 6'h04;
			OP_SRLV:    w[5:0] = 6'h06;
			OP_SRAV:    w[5:0] = 6'h07;
			OP_SYSCALL: w[5:0] = 6'h0C;
			OP_BREAK:   w[5:0] = 6'h0D;
			OP_MFHI:    w[5:0] = 6'h10;
			OP_MTHI:    w[5:0] = 6'h11;
			OP_MFLO:    w[5:0] = 6'h12;
			OP_MTLO:    w[5:0] = 6'h13;
			OP_MULT:    w[5:0] = 6'h18;
			OP_MULTU:   w[5:0] = 6'h19;
			OP_ADD:     w[5:0] = 6'h20;
			OP_ADDU:    w[5:0] = 6'h21;
			OP_SUB:     w[5:0] = 6'h22;
			OP_SUBU:    w[5:0] = 6'h23;
			OP_AND:     w[5:0] = 6'h24;
			OP_OR:      w[5:0] = 6'h25;
			OP_XOR:     w[5:0] = 6'h26;
			OP_NOR:     w[5:0] = 6'h27;
			OP_SLT:     w[5:0] = 6'h2A;
			OP_SLTU:    w[5:0] = 6'h2B;
			OP_TGE:     w[5:0] = 6'h30;
			OP_TGEU:    w[5:0] = 6'h31;
			OP_TLT:     w[5:0] = 6'h32;
			OP_TLTU:    w[5:0] = 6'h33;
			OP_TEQ:     w[5:0] = 6'h34;
			OP_TNE:     w[5:0] = 6'h36;
			OP_MADD:    w = {6'h1C, f[25:6], 6'h00};
			OP_MADDU:   w = {6'h1C, f[25:6], 6'h01};
			OP_MUL:     w = {6'h1C, f[25:6], 6'h02};
			OP_MSUB:    w = {6'h1C, f[25:6], 6'h04};
			OP_MSUBU:   w = {6'h1C, f[25:6], 6'h05};
			OP_CLZ:     w = {6'h1C, f[25:6], 6'h20};
			OP_CLO:     w = {6'h1C, f[25:6], 6'h21};
			OP_LUI:     w = {6'h0F, f[25:0]};
			OP_LB:      w = {6'h20, f[25:0]};
			OP_LH:      w = {6'h21, f[25:0]};
			OP_LW:      w = {6'h23, f[25:0]};
			OP_LBU:     w = {6'h24, f[25:0]};
			OP_LHU:     w = {6'h25, f[25:0]};
			OP_SB:      w = {6'h28, f[25:0]};
			OP_SH:      w = {6'h29, f[25:0]};
			OP_SW:      w = {6'h2B, f[25:0]};
			default:    w = {6'h3F, f[25:0]};
			endcase
		end
		return w;
	endfunction

	task automatic model_inst(input oper_t k, input logic imm_form, input word_t inst,
		input word_t a, input word_t b);
		word_t       imm_s;
		word_t       bb;
		word_t       ea;
		logic [4:0]  sh;
		logic [32:0] wide;
		logic [63:0] ps;
		logic [63:0] pu;
		logic [63:0] acc;
		int          cnt;
		imm_s = {{16{inst[15]}}, inst[15:0]};
		bb    = b;
		// logical immediates zero extend, the rest sign extend
		if (imm_form)
			bb = (k inside {OP_AND, OP_OR, OP_XOR}) ? {16'b0, inst[15:0]} : imm_s;
		sh  = (k inside {OP_SLLV, OP_SRLV, OP_SRAV}) ? a[4:0] : inst[10:6];
		ea  = a + imm_s;
		ps  = {{32{a[31]}}, a} * {{32{bb[31]}}, bb};
		pu  = {32'b0, a} * {32'b0, bb};
		acc = {m_hi, m_lo};
		exp_ret   = '0;
		exp_exc   = 1'b0;
		exp_code  = 5'd0;
		exp_ce    = 1'b0;
		exp_we    = 1'b0;
		exp_addr  = '0;
		exp_sel   = 4'b0000;
		exp_wdata = '0;
		cnt       = 0;
		case (k)
		OP_AND:  exp_ret = a & bb;
		OP_OR:   exp_ret = a | bb;
		OP_XOR:  exp_ret = a ^ bb;
		OP_NOR:  exp_ret = ~(a | bb);
		OP_LUI:  exp_ret = {inst[15:0], 16'b0};
		OP_ADDU: exp_ret = a + bb;
		OP_SUBU: exp_ret = a - bb;
		OP_ADD:
		begin
			wide     = {a[31], a} + {bb[31], bb};
			exp_ret  = wide[31:0];
			exp_exc  = wide[32] != wide[31];
			exp_code = EXC_OV;
		end
		OP_SUB:
		begin
			wide     = {a[31], a} - {bb[31], bb};
			exp_ret  = wide[31:0];
			exp_exc  = wide[32] != wide[31];
			exp_code = EXC_OV;
		end
		OP_SLT:  exp_ret = {31'b0, $signed(a) < $signed(bb)};
		OP_SLTU: exp_ret = {31'b0, a < bb};
		OP_SLL, OP_SLLV: exp_ret = bb << sh;
		OP_SRL, OP_SRLV: exp_ret = bb >> sh;
		OP_SRA, OP_SRAV: exp_ret = $signed(bb) >>> sh;
		OP_CLZ:
		begin
			while (cnt < 32 && a[31-cnt] == 1'b0)
				cnt++;
			exp_ret = cnt;
		end
		OP_CLO:
		begin
			while (cnt < 32 && a[31-cnt] == 1'b1)
				cnt++;
			exp_ret = cnt;
		end
		OP_MFHI:  exp_ret = m_hi;
		OP_MFLO:  exp_ret = m_lo;
		OP_MTHI:  m_hi = a;
		OP_MTLO:  m_lo = a;
		OP_MULT:  {m_hi, m_lo} = ps;
		OP_MULTU: {m_hi, m_lo} = pu;
		OP_MUL:   exp_ret = ps[31:0];
		OP_MADD:  {m_hi, m_lo} = acc + ps;
		OP_MADDU: {m_hi, m_lo} = acc + pu;
		OP_MSUB:  {m_hi, m_lo} = acc - ps;
		OP_MSUBU: {m_hi, m_lo} = acc - pu;
		OP_LB, OP_LBU, OP_SB: exp_sel = 4'b0001 << ea[1:0];
		OP_LH, OP_LHU, OP_SH:
		begin
			exp_sel = ea[1] ? 4'b1100 : 4'b0011;
			exp_exc = ea[0];
		end
		OP_LW, OP_SW:
		begin
			exp_sel = 4'b1111;
			exp_exc = |ea[1:0];
		end
		OP_TEQ:     exp_exc = a == bb;
		OP_TNE:     exp_exc = a != bb;
		OP_TGE:     exp_exc = $signed(a) >= $signed(bb);
		OP_TGEU:    exp_exc = a >= bb;
		OP_TLT:     exp_exc = $signed(a) < $signed(bb);
		OP_TLTU:    exp_exc = a < bb;
		OP_BREAK:   exp_exc = 1'b1;
		OP_SYSCALL: exp_exc = 1'b1;
		default:    exp_exc = 1'b1;
		endcase
		if (k inside {OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU})
			exp_code = EXC_TR;
		if (k == OP_BREAK)
			exp_code = EXC_BP;
		if (k == OP_SYSCALL)
			exp_code = EXC_SYS;
		if (k == OP_INVALID)
			exp_code = EXC_RI;
		if (k inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW})
		begin
			exp_ce    = 1'b1;
			exp_we    = k inside {OP_SB, OP_SH, OP_SW};
			exp_addr  = {ea[31:2], 2'b00};
			exp_wdata = exp_we ? b : '0;
			exp_code  = exp_we ? EXC_ADES : EXC_ADEL;
		end
	endtask

	task automatic run_inst(input string group, input oper_t k, input logic imm_form,
		input word_t a, input word_t b, input word_t f);
		string tag;
		word_t inst;
		word_t st;
		word_t rd;
		tag  = {group, " ", k.name()};
		inst = make_inst(k, imm_form, f);
		model_inst(k, imm_form, inst, a, b);
		apb_write(REG_INST, inst);
		apb_write(REG_OPA, a);
		apb_write(REG_OPB, b);
		apb_write(REG_CTRL, 32'd1);
		wait_idle(st);
		check_word({tag, " status flags"}, {29'b0, exp_exc, 2'b10}, {29'b0, st[2:0]});
		if (exp_exc)
		begin
			check_word({tag, " exception code"}, {27'b0, exp_code}, {27'b0, st[7:3]});
		end
		else
		begin
			apb_read(REG_RET, rd);
			check_word({tag, " ret"}, exp_ret, rd);
		end
		apb_read(REG_HI, rd);
		check_word({tag, " hi"}, m_hi, rd);
		apb_read(REG_LO, rd);
		check_word({tag, " lo"}, m_lo, rd);
		apb_read(REG_MEM_CTRL, rd);
		check_word({tag, " mem ctrl"}, {24'b0, exp_sel, 2'b00, exp_we, exp_ce}, rd);
		if (exp_ce)
		begin
			apb_read(REG_MEM_ADDR, rd);
			check_word({tag, " mem addr"}, exp_addr, rd);
			apb_read(REG_MEM_WDATA, rd);
			check_word({tag, " mem wdata"}, exp_wdata, rd);
		end
	endtask

	initial
	begin
		word_t r;
		word_t a;
		word_t b;
		word_t f;
		word_t rd;
		word_t inst;
		logic  err;
		logic  imm_form;
		oper_t k;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		m_hi    = '0;
		m_lo    = '0;
		rst     = 1'b1;
		repeat (10) @(posedge clk);
		#DLY;
		rst = 1'b0;

		apb_read(REG_STATUS, rd);
		check_word("reset status", 32'd0, rd);
		apb_read(REG_RET, rd);
		check_word("reset ret", 32'd0, rd);
		apb_read(REG_HI, rd);
		check_word("reset hi", 32'd0, rd);
		apb_read(REG_LO, rd);
		check_word("reset lo", 32'd0, rd);

		for (int i = 0; i < 200; i++)
		begin
			r = xorshift32();
			k = alu_ops[r % 19];
			a = xorshift32();
			b = xorshift32();
			f = xorshift32();
			// spread the leading bit counts
			if (r[9])
				a = a >> r[14:10];
			if (r[15])
				a = ~a;
			imm_form = r[8] && (k inside {OP_AND, OP_OR, OP_XOR, OP_ADD, OP_ADDU, OP_SLT,
				OP_SLTU});
			run_inst("alu", k, imm_form || k == OP_LUI, a, b, f);
		end

		for (int i = 0; i < 80; i++)
		begin
			r = xorshift32();
			k = mul_ops[r % 11];
			run_inst("muldiv", k, 1'b0, xorshift32(), xorshift32(), xorshift32());
		end

		for (int i = 0; i < 120; i++)
		begin
			r = xorshift32();
			k = mem_ops[r % 8];
			run_inst("mem", k, 1'b0, xorshift32(), xorshift32(), xorshift32());
		end

		for (int i = 0; i < 80; i++)
		begin
			r = xorshift32();
			k = exc_ops[r % 12];
			a = xorshift32();
			b = xorshift32();
			f = xorshift32();
			imm_form = r[8] && (k inside {OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU});
			// equal operands so that TEQ and the GE forms fire
			if (r[10])
			begin
				b = a;
				if (imm_form)
					a = {{16{f[15]}}, f[15:0]};
			end
			run_inst("trap", k, imm_form, a, b, f);
		end

		// refused accesses while a multiply runs
		a    = xorshift32();
		b    = xorshift32();
		inst = make_inst(OP_MULT, 1'b0, xorshift32());
		model_inst(OP_MULT, 1'b0, inst, a, b);
		apb_write(REG_INST, inst);
		apb_write(REG_OPA, a);
		apb_write(REG_OPB, b);
		apb_write(REG_CTRL, 32'd1);
		apb_read(REG_STATUS, rd);
		check_word("busy flag during multiply", 32'd1, {31'b0, rd[0]});
		apb_xfer(1'b1, REG_CTRL, 32'd1, rd, err);
		check_word("ctrl write while busy pslverr", 32'd1, {31'b0, err});
		apb_xfer(1'b1, REG_INST, 32'hFFFF_FFFF, rd, err);
		check_word("inst write while busy pslverr", 32'd1, {31'b0, err});
		apb_xfer(1'b0, 12'h040, 32'd0, rd, err);
		check_word("unmapped read pslverr", 32'd1, {31'b0, err});
		apb_xfer(1'b1, 12'h7F0, 32'h1234_5678, rd, err);
		check_word("unmapped write pslverr", 32'd1, {31'b0, err});
		wait_idle(rd);
		check_word("refused multiply status", 32'b010, {29'b0, rd[2:0]});
		apb_read(REG_HI, rd);
		check_word("refused multiply hi", m_hi, rd);
		apb_read(REG_LO, rd);
		check_word("refused multiply lo", m_lo, rd);
		apb_read(REG_INST, rd);
		check_word("refused multiply inst", inst, rd);

		if (dut0.result0.assert0.fail_cnt == 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			stop_run($sformatf("bound assertions on the result block failed %0d times",
				dut0.result0.assert0.fail_cnt));
		end
	end

endmodule

//--- tb/exu_assert.sv
module exu_assert(
	input logic            clk,
	input logic            rst,
	input logic            valid,
	input logic            stall,
	input logic            busy,
	input logic            done,
	input logic            except_occur,
	input exu_pkg::dword_t hilo
);

	logic        complete;
	int unsigned fail_cnt = 0;

	// same completion point as the result block
	assign complete = (valid || busy) && !stall;

	busy_done_excl: assert property (
		@(posedge clk) disable iff (rst) !(busy && done)
	) else
	begin
		fail_cnt++;
		$error("busy and done are high in the same cycle");
	end

	hilo_hold_on_exc: assert property (
		@(posedge clk) disable iff (rst) (complete && except_occur) |=> (hilo == $past(hilo))
	) else
	begin
		fail_cnt++;
		$error("HI/LO changed when an exception result was captured");
	end

	valid_not_busy: assert property (
		@(posedge clk) disable iff (rst) valid |-> !busy
	) else
	begin
		fail_cnt++;
		$error("a new operation arrived while the unit was busy");
	end

endmodule

bind exu_result exu_assert assert0 (
	.clk,
	.rst,
	.valid,
	.stall,
	.busy,
	.done,
	.except_occur,
	.hilo
);

//--- src/exu_top.sv
module exu_top #(
	parameter int APB_ADDR_W     = 12,
	parameter int MUL_RADIX_BITS = 1
)(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  exu_pkg::word_t        pwdata,
	output exu_pkg::word_t        prdata,
	output logic                  pready,
	output logic                  pslverr
);
	import exu_pkg::*;

	logic       start;
	word_t      inst;
	word_t      opa;
	word_t      opb;
	logic       valid;
	oper_t      op;
	word_t      src_a;
	word_t      src_b;
	word_t      imm;
	logic [4:0] shamt;
	word_t      ret;
	logic       hilo_we;
	dword_t     hilo_wdata;
	logic       mem_ce;
	logic       mem_we;
	word_t      mem_addr;
	logic [3:0] mem_sel;
	word_t      mem_wdata;
	logic       except_occur;
	exc_code_t  except_code;
	logic       stall;
	dword_t     hilo;
	logic       busy;
	logic       done;
	word_t      ret_q;
	logic       mem_ce_q;
	logic       mem_we_q;
	word_t      mem_addr_q;
	logic [3:0] mem_sel_q;
	word_t      mem_wdata_q;
	logic       except_occur_q;
	exc_code_t  except_code_q;

	exu_apb_regs #(
		.APB_ADDR_W(APB_ADDR_W)
	) apb_regs0 (
		.clk, .rst,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
		.start, .inst, .opa, .opb,
		.busy, .done, .hilo, .ret_q,
		.mem_ce_q, .mem_we_q, .mem_addr_q, .mem_sel_q, .mem_wdata_q,
		.except_occur_q, .except_code_q
	);

	exu_decode decode0 (
		.clk, .rst, .start, .inst, .opa, .opb,
		.valid, .op, .src_a, .src_b, .imm, .shamt
	);

	exu_execute #(
		.MUL_RADIX_BITS(MUL_RADIX_BITS)
	) execute0 (
		.clk, .rst, .valid, .op, .src_a, .src_b, .imm, .shamt, .hilo,
		.ret, .hilo_we, .hilo_wdata,
		.mem_ce, .mem_we, .mem_addr, .mem_sel, .mem_wdata,
		.except_occur, .except_code, .stall
	);

	exu_result result0 (
		.clk, .rst, .valid, .stall, .ret, .hilo_we, .hilo_wdata,
		.mem_ce, .mem_we, .mem_addr, .mem_sel, .mem_wdata,
		.except_occur, .except_code,
		.hilo, .busy, .done, .ret_q,
		.mem_ce_q, .mem_we_q, .mem_addr_q, .mem_sel_q, .mem_wdata_q,
		.except_occur_q, .except_code_q
	);

endmodule

//--- src/exu_apb_regs.sv
module exu_apb_regs #(
	parameter int APB_ADDR_W = 12
)(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  exu_pkg::word_t        pwdata,
	output exu_pkg::word_t        prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  start,
	output exu_pkg::word_t        inst,
	output exu_pkg::word_t        opa,
	output exu_pkg::word_t        opb,
	input  logic                  busy,
	input  logic                  done,
	input  exu_pkg::dword_t       hilo,
	input  exu_pkg::word_t        ret_q,
	input  logic                  mem_ce_q,
	input  logic                  mem_we_q,
	input  exu_pkg::word_t        mem_addr_q,
	input  logic [3:0]            mem_sel_q,
	input  exu_pkg::word_t        mem_wdata_q,
	input  logic                  except_occur_q,
	input  exu_pkg::exc_code_t    except_code_q
);
	import exu_pkg::*;

	logic access;
	logic wr;
	logic mapped;
	logic cmd_reg;

	assign access = psel && penable;
	assign pready = 1'b1;

	always_comb
	begin
		mapped  = 1'b1;
		cmd_reg = 1'b0;
		prdata  = '0;
		case (paddr)
		APB_ADDR_W'(REG_INST):
		begin
			cmd_reg = 1'b1;
			prdata  = inst;
		end
		APB_ADDR_W'(REG_OPA):
		begin
			cmd_reg = 1'b1;
			prdata  = opa;
		end
		APB_ADDR_W'(REG_OPB):
		begin
			cmd_reg = 1'b1;
			prdata  = opb;
		end
		APB_ADDR_W'(REG_CTRL):      cmd_reg = 1'b1;
		APB_ADDR_W'(REG_STATUS):
			prdata = {24'b0, except_code_q, except_occur_q, done, busy};
		APB_ADDR_W'(REG_RET):       prdata = ret_q;
		APB_ADDR_W'(REG_HI):        prdata = hilo[63:32];
		APB_ADDR_W'(REG_LO):        prdata = hilo[31:0];
		APB_ADDR_W'(REG_MEM_ADDR):  prdata = mem_addr_q;
		APB_ADDR_W'(REG_MEM_CTRL):  prdata = {24'b0, mem_sel_q, 2'b00, mem_we_q, mem_ce_q};
		APB_ADDR_W'(REG_MEM_WDATA): prdata = mem_wdata_q;
		default:                    mapped = 1'b0;
		endcase
	end

	// command registers are locked while a multiply runs
	assign pslverr = access && (!mapped || (pwrite && busy && cmd_reg));
	assign wr      = access && pwrite && !pslverr;
	assign start   = wr && (paddr == APB_ADDR_W'(REG_CTRL)) && pwdata[0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			inst <= '0;
			opa  <= '0;
			opb  <= '0;
		end
		else if (wr)
		begin
			if (paddr == APB_ADDR_W'(REG_INST))
			begin
				inst <= pwdata;
			end
			if (paddr == APB_ADDR_W'(REG_OPA))
			begin
				opa <= pwdata;
			end
			if (paddr == APB_ADDR_W'(REG_OPB))
			begin
				opb <= pwdata;
			end
		end
	end

endmodule

//--- src/exu_result.sv
module exu_result(
	input  logic               clk,
	input  logic               rst,
	input  logic               valid,
	input  logic               stall,
	input  exu_pkg::word_t     ret,
	input  logic               hilo_we,
	input  exu_pkg::dword_t    hilo_wdata,
	input  logic               mem_ce,
	input  logic               mem_we,
	input  exu_pkg::word_t     mem_addr,
	input  logic [3:0]         mem_sel,
	input  exu_pkg::word_t     mem_wdata,
	input  logic               except_occur,
	input  exu_pkg::exc_code_t except_code,
	output exu_pkg::dword_t    hilo,
	output logic               busy,
	output logic               done,
	output exu_pkg::word_t     ret_q,
	output logic               mem_ce_q,
	output logic               mem_we_q,
	output exu_pkg::word_t     mem_addr_q,
	output logic [3:0]         mem_sel_q,
	output exu_pkg::word_t     mem_wdata_q,
	output logic               except_occur_q,
	output exu_pkg::exc_code_t except_code_q
);
	import exu_pkg::*;

	logic complete;

	// first edge with the stage free after valid
	assign complete = (valid || busy) && !stall;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy           <= 1'b0;
			done           <= 1'b0;
			hilo           <= '0;
			ret_q          <= '0;
			mem_ce_q       <= 1'b0;
			mem_we_q       <= 1'b0;
			mem_addr_q     <= '0;
			mem_sel_q      <= '0;
			mem_wdata_q    <= '0;
			except_occur_q <= 1'b0;
			except_code_q  <= EXC_NONE;
		end
		else if (complete)
		begin
			busy           <= 1'b0;
			done           <= 1'b1;
			ret_q          <= ret;
			mem_ce_q       <= mem_ce;
			mem_we_q       <= mem_we;
			mem_addr_q     <= mem_addr;
			mem_sel_q      <= mem_sel;
			mem_wdata_q    <= mem_wdata;
			except_occur_q <= except_occur;
			except_code_q  <= except_code;
			if (hilo_we && !except_occur)
			begin
				hilo <= hilo_wdata;
			end
		end
		else if (valid)
		begin
			// multiply in flight
			busy <= 1'b1;
			done <= 1'b0;
		end
	end

endmodule

//--- src/exu_execute.sv
module exu_execute #(
	parameter int MUL_RADIX_BITS = 1
)(
	input  logic               clk,
	input  logic               rst,
	input  logic               valid,
	input  exu_pkg::oper_t     op,
	input  exu_pkg::word_t     src_a,
	input  exu_pkg::word_t     src_b,
	input  exu_pkg::word_t     imm,
	input  logic [4:0]         shamt,
	input  exu_pkg::dword_t    hilo,
	output exu_pkg::word_t     ret,
	output logic               hilo_we,
	output exu_pkg::dword_t    hilo_wdata,
	output logic               mem_ce,
	output logic               mem_we,
	output exu_pkg::word_t     mem_addr,
	output logic [3:0]         mem_sel,
	output exu_pkg::word_t     mem_wdata,
	output logic               except_occur,
	output exu_pkg::exc_code_t except_code,
	output logic               stall
);
	import exu_pkg::*;

	function automatic word_t count_lead(input word_t val, input logic bit_val);
		word_t cnt;
		logic  stop;
		cnt  = '0;
		stop = 1'b0;
		for (int i = 31; i >= 0; i--)
		begin
			if (!stop && val[i] == bit_val)
			begin
				cnt = cnt + 1'b1;
			end
			else
			begin
				stop = 1'b1;
			end
		end
		return cnt;
	endfunction

	word_t  sum;
	word_t  diff;
	word_t  ea;
	logic   ov_add;
	logic   ov_sub;
	logic   signed_lt;
	logic   unsigned_lt;
	logic   is_load;
	logic   is_store;
	logic   is_mul;
	dword_t product;

	assign sum  = src_a + src_b;
	assign diff = src_a - src_b;
	assign ov_add = (src_a[31] == src_b[31]) && (sum[31] != src_a[31]);
	assign ov_sub = (src_a[31] != src_b[31]) && (diff[31] != src_a[31]);
	assign signed_lt   = $signed(src_a) < $signed(src_b);
	assign unsigned_lt = src_a < src_b;

	assign is_mul = op inside {OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};

	exu_multi_cyc #(
		.MUL_RADIX_BITS(MUL_RADIX_BITS)
	) multi_cyc0 (
		.clk,
		.rst,
		.start(valid && is_mul),
		.op,
		.src_a,
		.src_b,
		.hilo,
		.product,
		.busy(stall)
	);

	always_comb
	begin
		ret        = '0;
		hilo_we    = 1'b0;
		hilo_wdata = product;
		case (op)
		OP_AND:  ret = src_a & src_b;
		OP_OR:   ret = src_a | src_b;
		OP_XOR:  ret = src_a ^ src_b;
		OP_NOR:  ret = ~(src_a | src_b);
		OP_LUI:  ret = {imm[15:0], 16'b0};
		OP_ADD, OP_ADDU: ret = sum;
		OP_SUB, OP_SUBU: ret = diff;
		OP_SLT:  ret = {31'b0, signed_lt};
		OP_SLTU: ret = {31'b0, unsigned_lt};
		OP_SLL, OP_SLLV: ret = src_b << shamt;
		OP_SRL, OP_SRLV: ret = src_b >> shamt;
		OP_SRA, OP_SRAV: ret = $signed(src_b) >>> shamt;
		OP_CLZ:  ret = count_lead(src_a, 1'b0);
		OP_CLO:  ret = count_lead(src_a, 1'b1);
		OP_MFHI: ret = hilo[63:32];
		OP_MFLO: ret = hilo[31:0];
		OP_MTHI:
		begin
			hilo_we    = 1'b1;
			hilo_wdata = {src_a, hilo[31:0]};
		end
		OP_MTLO:
		begin
			hilo_we    = 1'b1;
			hilo_wdata = {hilo[63:32], src_a};
		end
		OP_MUL:  ret = product[31:0];
		OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: hilo_we = 1'b1;
		default: ret = '0;
		endcase
	end

	// memory request
	assign ea        = src_a + imm;
	assign is_load   = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
	assign is_store  = op inside {OP_SB, OP_SH, OP_SW};
	assign mem_ce    = is_load || is_store;
	assign mem_we    = is_store;
	assign mem_addr  = {ea[31:2], 2'b00};
	assign mem_wdata = is_store ? src_b : '0;

	always_comb
	begin
		case (op)
		OP_LB, OP_LBU, OP_SB: mem_sel = 4'b0001 << ea[1:0];
		OP_LH, OP_LHU, OP_SH: mem_sel = ea[1] ? 4'b1100 : 4'b0011;
		OP_LW, OP_SW:         mem_sel = 4'b1111;
		default:              mem_sel = 4'b0000;
		endcase
	end

	always_comb
	begin
		except_occur = 1'b0;
		except_code  = EXC_TR;
		case (op)
		OP_TEQ:  except_occur = (src_a == src_b);
		OP_TNE:  except_occur = (src_a != src_b);
		OP_TGE:  except_occur = !signed_lt;
		OP_TGEU: except_occur = !unsigned_lt;
		OP_TLT:  except_occur = signed_lt;
		OP_TLTU: except_occur = unsigned_lt;
		OP_ADD:
		begin
			except_occur = ov_add;
			except_code  = EXC_OV;
		end
		OP_SUB:
		begin
			except_occur = ov_sub;
			except_code  = EXC_OV;
		end
		OP_LH, OP_LHU, OP_SH:
		begin
			except_occur = ea[0];
			except_code  = (op == OP_SH) ? EXC_ADES : EXC_ADEL;
		end
		OP_LW, OP_SW:
		begin
			except_occur = ea[1] | ea[0];
			except_code  = (op == OP_SW) ? EXC_ADES : EXC_ADEL;
		end
		OP_BREAK:
		begin
			except_occur = 1'b1;
			except_code  = EXC_BP;
		end
		OP_SYSCALL:
		begin
			except_occur = 1'b1;
			except_code  = EXC_SYS;
		end
		OP_INVALID:
		begin
			except_occur = 1'b1;
			except_code  = EXC_RI;
		end
		default: except_code = EXC_NONE;
		endcase
	end

endmodule

//--- src/exu_multi_cyc.sv
module exu_multi_cyc #(
	parameter int MUL_RADIX_BITS = 1
)(
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  exu_pkg::oper_t  op,
	input  exu_pkg::word_t  src_a,
	input  exu_pkg::word_t  src_b,
	input  exu_pkg::dword_t hilo,
	output exu_pkg::dword_t product,
	output logic            busy
);
	import exu_pkg::*;

	localparam int STEPS = 32 / MUL_RADIX_BITS;

	logic [5:0] cnt;
	logic       is_signed;
	logic       neg;
	logic       do_acc;
	logic       do_sub;
	word_t      abs_a;
	word_t      abs_b;
	word_t      mplier;
	word_t      cur_mplier;
	dword_t     acc;
	dword_t     mcand;
	dword_t     cur_acc;
	dword_t     cur_mcand;
	dword_t     abs_prod;
	dword_t     base;

	assign is_signed = (op == OP_MULT) || (op == OP_MUL) || (op == OP_MADD) || (op == OP_MSUB);
	assign abs_a = (is_signed && src_a[31]) ? -src_a : src_a;
	assign abs_b = (is_signed && src_b[31]) ? -src_b : src_b;

	// first step runs in the start cycle straight from the operands
	assign cur_acc    = start ? '0 : acc;
	assign cur_mcand  = start ? {32'b0, abs_a} : mcand;
	assign cur_mplier = start ? abs_b : mplier;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt <= '0;
		end
		else if (start)
		begin
			cnt <= 6'(STEPS - 1);
		end
		else if (cnt != '0)
		begin
			cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (busy)
		begin
			acc    <= cur_acc + cur_mcand * cur_mplier[MUL_RADIX_BITS-1:0];
			mcand  <= cur_mcand << MUL_RADIX_BITS;
			mplier <= cur_mplier >> MUL_RADIX_BITS;
		end
		if (start)
		begin
			neg    <= is_signed && (src_a[31] ^ src_b[31]);
			do_acc <= op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
			do_sub <= op inside {OP_MSUB, OP_MSUBU};
		end
	end

	assign abs_prod = neg ? -acc : acc;
	assign base     = do_acc ? hilo : '0;
	assign product  = do_sub ? base - abs_prod : base + abs_prod;
	assign busy     = start || (cnt != '0);

endmodule

//--- src/exu_decode.sv
module exu_decode(
	input  logic           clk,
	input  logic           rst,
	input  logic           start,
	input  exu_pkg::word_t inst,
	input  exu_pkg::word_t opa,
	input  exu_pkg::word_t opb,
	output logic           valid,
	output exu_pkg::oper_t op,
	output exu_pkg::word_t src_a,
	output exu_pkg::word_t src_b,
	output exu_pkg::word_t imm,
	output logic [4:0]     shamt
);
	import exu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rt;
	oper_t      dec_op;
	logic       use_imm;
	word_t      dec_imm;
	logic [4:0] dec_shamt;

	assign opcode = inst[31:26];
	assign funct  = inst[5:0];
	assign rt     = inst[20:16];

	// logical immediates are zero extended
	assign dec_imm = (opcode inside {6'h0C, 6'h0D, 6'h0E}) ?
		{16'b0, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};

	always_comb
	begin
		dec_op  = OP_INVALID;
		use_imm = 1'b0;
		case (opcode)
		6'h00:
			case (funct)
			6'h00: dec_op = OP_SLL;
			6'h02: dec_op = OP_SRL;
			6'h03: dec_op = OP_SRA;
			6'h04: dec_op = OP_SLLV;
			6'h06: dec_op = OP_SRLV;
			6'h07: dec_op = OP_SRAV;
			6'h0C: dec_op = OP_SYSCALL;
			6'h0D: dec_op = OP_BREAK;
			6'h10: dec_op = OP_MFHI;
			6'h11: dec_op = OP_MTHI;
			6'h12: dec_op = OP_MFLO;
			6'h13: dec_op = OP_MTLO;
			6'h18: dec_op = OP_MULT;
			6'h19: dec_op = OP_MULTU;
			6'h20: dec_op = OP_ADD;
			6'h21: dec_op = OP_ADDU;
			6'h22: dec_op = OP_SUB;
			6'h23: dec_op = OP_SUBU;
			6'h24: dec_op = OP_AND;
			6'h25: dec_op = OP_OR;
			6'h26: dec_op = OP_XOR;
			6'h27: dec_op = OP_NOR;
			6'h2A: dec_op = OP_SLT;
			6'h2B: dec_op = OP_SLTU;
			6'h30: dec_op = OP_TGE;
			6'h31: dec_op = OP_TGEU;
			6'h32: dec_op = OP_TLT;
			6'h33: dec_op = OP_TLTU;
			6'h34: dec_op = OP_TEQ;
			6'h36: dec_op = OP_TNE;
			default: dec_op = OP_INVALID;
			endcase
		// REGIMM trap immediates
		6'h01:
		begin
			use_imm = 1'b1;
			case (rt)
			5'h08: dec_op = OP_TGE;
			5'h09: dec_op = OP_TGEU;
			5'h0A: dec_op = OP_TLT;
			5'h0B: dec_op = OP_TLTU;
			5'h0C: dec_op = OP_TEQ;
			5'h0E: dec_op = OP_TNE;
			default: dec_op = OP_INVALID;
			endcase
		end
		6'h1C:
			case (funct)
			6'h00: dec_op = OP_MADD;
			6'h01: dec_op = OP_MADDU;
			6'h02: dec_op = OP_MUL;
			6'h04: dec_op = OP_MSUB;
			6'h05: dec_op = OP_MSUBU;
			6'h20: dec_op = OP_CLZ;
			6'h21: dec_op = OP_CLO;
			default: dec_op = OP_INVALID;
			endcase
		6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F:
		begin
			use_imm = 1'b1;
			case (opcode[2:0])
			3'd0: dec_op = OP_ADD;
			3'd1: dec_op = OP_ADDU;
			3'd2: dec_op = OP_SLT;
			3'd3: dec_op = OP_SLTU;
			3'd4: dec_op = OP_AND;
			3'd5: dec_op = OP_OR;
			3'd6: dec_op = OP_XOR;
			default: dec_op = OP_LUI;
			endcase
		end
		6'h20: dec_op = OP_LB;
		6'h21: dec_op = OP_LH;
		6'h23: dec_op = OP_LW;
		6'h24: dec_op = OP_LBU;
		6'h25: dec_op = OP_LHU;
		6'h28: dec_op = OP_SB;
		6'h29: dec_op = OP_SH;
		6'h2B: dec_op = OP_SW;
		default: dec_op = OP_INVALID;
		endcase
	end

	// variable shifts take the amount from rs
	assign dec_shamt = (dec_op inside {OP_SLLV, OP_SRLV, OP_SRAV}) ? opa[4:0] : inst[10:6];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid <= 1'b0;
			op    <= OP_NOP;
		end
		else
		begin
			valid <= start;
			if (start)
			begin
				op <= dec_op;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			src_a <= opa;
			src_b <= use_imm ? dec_imm : opb;
			imm   <= dec_imm;
			shamt <= dec_shamt;
		end
	end

endmodule

//--- src/exu_pkg.sv
package exu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;

	typedef enum logic [5:0] {
		OP_NOP, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
		OP_CLZ, OP_CLO,
		OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
		OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
		OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
		OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU,
		OP_BREAK, OP_SYSCALL,
		OP_INVALID
	} oper_t;

	// MIPS cause register encodings
	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12,
		EXC_TR   = 5'd13
	} exc_code_t;

	// register map, byte offsets
	localparam logic [7:0] REG_INST      = 8'h00;
	localparam logic [7:0] REG_OPA       = 8'h04;
	localparam logic [7:0] REG_OPB       = 8'h08;
	localparam logic [7:0] REG_CTRL      = 8'h0C;
	localparam logic [7:0] REG_STATUS    = 8'h10;
	localparam logic [7:0] REG_RET       = 8'h14;
	localparam logic [7:0] REG_HI        = 8'h18;
	localparam logic [7:0] REG_LO        = 8'h1C;
	localparam logic [7:0] REG_MEM_ADDR  = 8'h20;
	localparam logic [7:0] REG_MEM_CTRL  = 8'h24;
	localparam logic [7:0] REG_MEM_WDATA = 8'h28;

endpackage
